// File: ac_defines.svh
// ============================================================
// word width, multiply step count and opcode field values
// for the accumulator section
// ============================================================

`ifndef AC_DEFINES_SVH
`define AC_DEFINES_SVH

// data path sizes
`define AC_WORD_W       12
`define AC_MUL_STEPS    12

// major opcode, instruction bits 0 to 2
`define AC_OP_AND       3'o0
`define AC_OP_TAD       3'o1
`define AC_OP_DCA       3'o3
`define AC_OP_OPR       3'o7

// EAE code field of MUL (7405), instruction bits 8 to 10
`define AC_MUL_CODE     3'b010

`define AC_RESET_WORD   12'o0000

`endif

// File: ac_pkg.sv
// ============================================================
// shared types of the accumulator section
// word and instruction types, class and phase enums
// ============================================================

`include "ac_defines.svh"

package ac_pkg;

    // bit 0 is the most significant bit, as on the original machine
    typedef logic [0:`AC_WORD_W-1] word_t;

    // link in bit 0, ac in bits 1 to 12
    typedef logic [0:`AC_WORD_W]   link_word_t;

    typedef logic [0:`AC_WORD_W-1] instr_t;

    typedef enum logic [2:0] {
        OPC_NONE,   // dropped or unsupported
        OPC_AND,
        OPC_TAD,
        OPC_DCA,
        OPC_OPR1,   // group-1 operate
        OPC_OPR3    // group-3 mq and eae
    } op_class_e;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_1,
        PH_2,
        PH_3,
        PH_MUL      // waiting on the multiplier
    } phase_e;

endpackage

// File: ac_sequencer.sv
// ============================================================
// instruction register, class decode and phase sequencer
// issues the multiply start and waits for its finish
// ============================================================

`include "ac_defines.svh"

module ac_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  ac_pkg::instr_t    instr,
    input  logic              mul_done,
    output ac_pkg::phase_e    phase,
    output ac_pkg::op_class_e op_class,
    output ac_pkg::instr_t    instr_q,
    output logic              mul_start,
    output logic              busy,
    output logic              done
);

    logic accept;
    logic is_mul;

    assign busy   = (phase != ac_pkg::PH_IDLE) || done; // covers the done cycle
    assign accept = start && !busy;                     // start while busy is dropped

    always_comb
    begin
        op_class = ac_pkg::OPC_NONE;
        case (instr_q[0:2])
            `AC_OP_AND: op_class = ac_pkg::OPC_AND;
            `AC_OP_TAD: op_class = ac_pkg::OPC_TAD;
            `AC_OP_DCA: op_class = ac_pkg::OPC_DCA;
            `AC_OP_OPR:
            begin
                if (!instr_q[3])
                    op_class = ac_pkg::OPC_OPR1;
                else if (instr_q[11])
                    op_class = ac_pkg::OPC_OPR3; // group 2 stays none
            end
            default: ;
        endcase
    end

    assign is_mul    = (op_class == ac_pkg::OPC_OPR3) && (instr_q[8:10] == `AC_MUL_CODE);
    assign mul_start = (phase == ac_pkg::PH_3) && is_mul;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            phase   <= ac_pkg::PH_IDLE;
            instr_q <= '0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (phase)
                ac_pkg::PH_IDLE:
                begin
                    if (accept)
                    begin
                        instr_q <= instr;
                        phase   <= ac_pkg::PH_1;
                    end
                end
                ac_pkg::PH_1: phase <= ac_pkg::PH_2;
                ac_pkg::PH_2: phase <= ac_pkg::PH_3;
                ac_pkg::PH_3:
                begin
                    if (is_mul)
                        phase <= ac_pkg::PH_MUL; // multiplier launched this cycle
                    else
                    begin
                        phase <= ac_pkg::PH_IDLE;
                        done  <= 1'b1;
                    end
                end
                ac_pkg::PH_MUL:
                begin
                    if (mul_done)
                    begin
                        phase <= ac_pkg::PH_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: phase <= ac_pkg::PH_IDLE;
            endcase
        end
    end

endmodule

// File: opr1_logic.sv
// ============================================================
// group-1 operate micro-ops, combinational
// clear and complement, increment, rotates and byte swap
// ============================================================

module opr1_logic (
    input  ac_pkg::instr_t instr_q,
    input  ac_pkg::phase_e phase,
    input  ac_pkg::word_t  ac_in,
    input  logic           l_in,
    output ac_pkg::word_t  ac_out,
    output logic           l_out
);

    ac_pkg::link_word_t inc_sum;

    assign inc_sum = {l_in, ac_in} + 1'b1; // carry ends up in the link

    always_comb
    begin
        ac_out = ac_in;
        l_out  = l_in;
        case (phase)
            ac_pkg::PH_1:
            begin
                if (instr_q[4])
                    ac_out = '0;        // cla
                if (instr_q[5])
                    l_out = 1'b0;       // cll
                if (instr_q[6])
                    ac_out = ~ac_out;   // cma, after the clear
                if (instr_q[7])
                    l_out = ~l_out;     // cml
            end
            ac_pkg::PH_2:
            begin
                if (instr_q[11])
                    {l_out, ac_out} = inc_sum; // iac
            end
            ac_pkg::PH_3:
            begin
                case (instr_q[8:10])
                    3'b001: ac_out = {ac_in[6:11], ac_in[0:5]}; // bsw
                    3'b010:                                     // ral
                    begin
                        ac_out = {ac_in[1:11], l_in};
                        l_out  = ac_in[0];
                    end
                    3'b011:                                     // rtl
                    begin
                        ac_out = {ac_in[2:11], l_in, ac_in[0]};
                        l_out  = ac_in[1];
                    end
                    3'b100:                                     // rar
                    begin
                        ac_out = {l_in, ac_in[0:10]};
                        l_out  = ac_in[11];
                    end
                    3'b101:                                     // rtr
                    begin
                        ac_out = {ac_in[11], l_in, ac_in[0:9]};
                        l_out  = ac_in[10];
                    end
                    default: ; // no rotate
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: eae_multiplier.sv
// ============================================================
// EAE multiplier, one shift-and-add step per cycle
// product is mq * multiplicand + ac
// ============================================================

`include "ac_defines.svh"

module eae_multiplier (
    input  logic          clk,
    input  logic          reset,
    input  logic          mul_start,
    input  ac_pkg::word_t multiplicand,
    input  ac_pkg::word_t mq_in,
    input  ac_pkg::word_t ac_in,
    output ac_pkg::word_t prod_hi,
    output ac_pkg::word_t prod_lo,
    output logic          mul_done
);

    localparam int CNT_W = $clog2(`AC_MUL_STEPS + 1);

    logic [CNT_W-1:0]   step_cnt;     // steps still to go
    ac_pkg::word_t      mcand;
    ac_pkg::word_t      hi;
    ac_pkg::word_t      lo;
    ac_pkg::link_word_t sum;          // carry in bit 0

    // add the multiplicand when the low bit of mq is set
    assign sum = {1'b0, hi} + (lo[11] ? {1'b0, mcand} : '0);

    // result of the current step, taken by the datapath on the last one
    assign prod_hi  = sum[0:11];
    assign prod_lo  = {sum[12], lo[0:10]};
    assign mul_done = (step_cnt == CNT_W'(1));

    always_ff @(posedge clk)
    begin
        if (reset)
            step_cnt <= '0;
        else if (mul_start)
            step_cnt <= CNT_W'(`AC_MUL_STEPS);
        else if (step_cnt != '0)
            step_cnt <= step_cnt - 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (mul_start)
        begin
            mcand <= multiplicand;
            hi    <= ac_in;        // ac lands in the low half after 12 shifts
            lo    <= mq_in;
        end
        else if (step_cnt != '0)
        begin
            hi <= prod_hi;         // shift the 25-bit pair right
            lo <= prod_lo;
        end
    end

endmodule

// File: ac_datapath.sv
// ============================================================
// ac, link and mq registers with per-phase source select
// memory reference, group-3 mq moves and multiply result
// ============================================================

`include "ac_defines.svh"

module ac_datapath (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  ac_pkg::phase_e    phase,
    input  ac_pkg::op_class_e op_class,
    input  ac_pkg::instr_t    instr_q,
    input  ac_pkg::word_t     operand,
    input  ac_pkg::word_t     opr_ac,
    input  logic              opr_l,
    input  ac_pkg::word_t     prod_hi,
    input  ac_pkg::word_t     prod_lo,
    input  logic              mul_done,
    output ac_pkg::word_t     ac,
    output ac_pkg::word_t     mq,
    output ac_pkg::word_t     operand_q,
    output logic              l
);

    logic opr1_active;

    assign opr1_active = (op_class == ac_pkg::OPC_OPR1) &&
                         (phase inside {ac_pkg::PH_1, ac_pkg::PH_2, ac_pkg::PH_3});

    // only a start seen in idle loads a new operand
    always_ff @(posedge clk)
    begin
        if (start && (phase == ac_pkg::PH_IDLE))
            operand_q <= operand;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ac <= `AC_RESET_WORD;
            mq <= `AC_RESET_WORD;
            l  <= 1'b0;
        end
        else if (mul_done)
        begin
            ac <= prod_hi;
            mq <= prod_lo;
            l  <= 1'b0;
        end
        else if (opr1_active)
        begin
            ac <= opr_ac;       // operate logic already sequenced by phase
            l  <= opr_l;
        end
        else if ((phase == ac_pkg::PH_1) && (op_class == ac_pkg::OPC_OPR3))
        begin
            case ({instr_q[4], instr_q[5], instr_q[7]}) // cla, mqa, mql
                3'b001: {ac, mq} <= {`AC_RESET_WORD, ac}; // mql
                3'b010: ac <= ac | mq;                    // mqa
                3'b011: {ac, mq} <= {mq, ac};             // swp
                3'b100: ac <= `AC_RESET_WORD;             // cla
                3'b101: {ac, mq} <= '0;                   // cam
                3'b110: ac <= mq;                         // acl
                3'b111: {ac, mq} <= {mq, `AC_RESET_WORD}; // cla swp
                default: ;
            endcase
        end
        else if ((phase == ac_pkg::PH_2) && (op_class == ac_pkg::OPC_AND))
            ac <= ac & operand_q;
        else if ((phase == ac_pkg::PH_2) && (op_class == ac_pkg::OPC_TAD))
            {l, ac} <= {l, ac} + {1'b0, operand_q}; // carry flips the link
        else if ((phase == ac_pkg::PH_3) && (op_class == ac_pkg::OPC_DCA))
            ac <= `AC_RESET_WORD; // store happens outside, ac cleared
    end

endmodule

// File: ac_unit_top.sv
// ============================================================
// accumulator section top level
// sequencer, datapath, group-1 logic and EAE multiplier
// ============================================================

module ac_unit_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  ac_pkg::instr_t instr,
    input  ac_pkg::word_t  operand,
    output ac_pkg::word_t  ac,
    output ac_pkg::word_t  mq,
    output logic           l,
    output logic           busy,
    output logic           done
);

    ac_pkg::phase_e    phase;
    ac_pkg::op_class_e op_class;
    ac_pkg::instr_t    instr_q;
    ac_pkg::word_t     operand_q;
    ac_pkg::word_t     opr_ac;
    ac_pkg::word_t     prod_hi;
    ac_pkg::word_t     prod_lo;
    logic              opr_l;
    logic              mul_start;
    logic              mul_done;

    ac_sequencer u_seq (
        .clk(clk), .reset(reset), .start(start), .instr(instr), .mul_done(mul_done),
        .phase(phase), .op_class(op_class), .instr_q(instr_q),
        .mul_start(mul_start), .busy(busy), .done(done)
    );

    opr1_logic u_opr1 (
        .instr_q(instr_q), .phase(phase), .ac_in(ac), .l_in(l),
        .ac_out(opr_ac), .l_out(opr_l)
    );

    eae_multiplier u_mul (
        .clk(clk), .reset(reset), .mul_start(mul_start), .multiplicand(operand_q),
        .mq_in(mq), .ac_in(ac), .prod_hi(prod_hi), .prod_lo(prod_lo), .mul_done(mul_done)
    );

    ac_datapath u_dp (
        .clk(clk), .reset(reset), .start(start), .phase(phase), .op_class(op_class),
        .instr_q(instr_q), .operand(operand), .opr_ac(opr_ac), .opr_l(opr_l),
        .prod_hi(prod_hi), .prod_lo(prod_lo), .mul_done(mul_done),
        .ac(ac), .mq(mq), .operand_q(operand_q), .l(l)
    );

endmodule

// File: ac_unit_props.sv
// ============================================================
// concurrent checks on the busy and done strobes
// bound into the accumulator section top level
// ============================================================

module ac_unit_props (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic done
);

    timeunit 1ns;
    timeprecision 100ps;

    done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    // busy already high in the cycle before done
    done_in_busy: assert property (@(posedge clk) disable iff (reset) done |-> $past(busy))
        else $error("done raised while busy was low");

    // sync reset clears the phase and done on the same edge
    idle_after_reset: assert property (@(posedge clk) reset |=> !busy)
        else $error("busy high in the first cycle after reset");

endmodule

bind ac_unit_top ac_unit_props u_props (
    .clk(clk), .reset(reset), .busy(busy), .done(done)
);

// File: tb_ac_unit.sv
// ============================================================
// testbench for the accumulator section
// stimulus table, reference model, compare tasks, timeout
// ============================================================

`include "ac_defines.svh"

module tb_ac_unit;

    timeunit 1ns;
    timeprecision 100ps;

    logic           clk;
    logic           reset;
    logic           start;
    ac_pkg::instr_t instr;
    ac_pkg::word_t  operand;
    ac_pkg::word_t  ac;
    ac_pkg::word_t  mq;
    logic           l;
    logic           busy;
    logic           done;

    string          tab_name[$];
    ac_pkg::instr_t tab_instr[$];
    ac_pkg::word_t  tab_operand[$];
    bit             tab_rand[$];     // operand drawn at run time
    bit             tab_fixed[$];    // expected values written in
    ac_pkg::word_t  tab_ac[$];
    logic           tab_l[$];
    ac_pkg::word_t  tab_mq[$];

    ac_pkg::word_t  m_ac = '0;       // reference model state
    ac_pkg::word_t  m_mq = '0;
    logic           m_l  = 1'b0;

    int error_cnt    = 0;
    int pass_cnt     = 0;
    int fail_cnt     = 0;
    int cycle_cnt    = 0;
    int limit_cycles = 0;

    ac_unit_top dut0 (
        .clk(clk), .reset(reset), .start(start), .instr(instr), .operand(operand),
        .ac(ac), .mq(mq), .l(l), .busy(busy), .done(done)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if ((limit_cycles > 0) && (cycle_cnt >= limit_cycles))
        begin
            $display("timeout: no finish within %0d cycles, done never came", limit_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input ac_pkg::word_t got,
                              input ac_pkg::word_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %o, expected %o", $time, name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic check_link(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic add_row(input string name, input ac_pkg::instr_t i, input ac_pkg::word_t op,
                           input bit rnd, input bit fixed, input ac_pkg::word_t e_ac,
                           input logic e_l, input ac_pkg::word_t e_mq);
        tab_name.push_back(name);
        tab_instr.push_back(i);
        tab_operand.push_back(op);
        tab_rand.push_back(rnd);
        tab_fixed.push_back(fixed);
        tab_ac.push_back(e_ac);
        tab_l.push_back(e_l);
        tab_mq.push_back(e_mq);
    endtask

    // instruction semantics, one call per executed row
    task automatic model_step(input ac_pkg::instr_t i, input ac_pkg::word_t op);
        logic [12:0]   ring;
        logic [23:0]   prod;
        ac_pkg::word_t a0;
        ac_pkg::word_t new_mq;
        case (i[0:2])
            3'o0: m_ac = m_ac & op;
            3'o1: {m_l, m_ac} = {m_l, m_ac} + 13'(op);
            3'o3: m_ac = '0;
            3'o7:
            begin
                if (!i[3])
                begin
                    if (i[4]) m_ac = '0;             // clear first
                    if (i[5]) m_l = 1'b0;
                    if (i[6]) m_ac = ~m_ac;          // then complement
                    if (i[7]) m_l = ~m_l;
                    if (i[11]) {m_l, m_ac} = {m_l, m_ac} + 13'd1;
                    ring = {m_l, m_ac};
                    if (i[8]) repeat (i[10] ? 2 : 1) ring = {ring[0], ring[12:1]};
                    if (i[9]) repeat (i[10] ? 2 : 1) ring = {ring[11:0], ring[12]};
                    {m_l, m_ac} = ring;
                    if (i[8:10] == 3'b001)
                        m_ac = (m_ac << 6) | (m_ac >> 6); // byte swap
                end
                else if (i[11])
                begin
                    a0     = i[4] ? '0 : m_ac;       // cla ahead of the mq moves
                    new_mq = i[7] ? a0 : m_mq;
                    m_ac   = (i[7] ? '0 : a0) | (i[5] ? m_mq : '0);
                    m_mq   = new_mq;
                    if (i[8:10] == 3'b010)
                    begin
                        prod = 24'(m_mq) * 24'(op) + 24'(m_ac);
                        {m_ac, m_mq} = prod;
                        m_l = 1'b0;
                    end
                end
            end
            default: ;
        endcase
    endtask

    task automatic build_table();
        add_row("nop",         12'o7000, 12'o0000, 0, 1, 12'o0000, 0, 12'o0000);
        add_row("tad",         12'o1000, 12'o0000, 1, 0, 12'o0000, 0, 12'o0000);
        add_row("and",         12'o0000, 12'o0000, 1, 0, 12'o0000, 0, 12'o0000);
        add_row("tad",         12'o1000, 12'o0000, 1, 0, 12'o0000, 0, 12'o0000);
        add_row("dca",         12'o3000, 12'o0000, 0, 0, 12'o0000, 0, 12'o0000);
        add_row("cla cll",     12'o7300, 12'o0000, 0, 1, 12'o0000, 0, 12'o0000);
        add_row("cla cma iac", 12'o7241, 12'o0000, 0, 1, 12'o0000, 1, 12'o0000);
        add_row("cla cll",     12'o7300, 12'o0000, 0, 1, 12'o0000, 0, 12'o0000);
        add_row("tad",         12'o1000, 12'o4321, 0, 1, 12'o4321, 0, 12'o0000);
        add_row("ral",         12'o7004, 12'o0000, 0, 1, 12'o0642, 1, 12'o0000);
        add_row("rtr",         12'o7012, 12'o0000, 0, 1, 12'o2150, 1, 12'o0000);
        add_row("bsw",         12'o7002, 12'o0000, 0, 1, 12'o5021, 1, 12'o0000);
        add_row("cla cll",     12'o7300, 12'o0000, 0, 1, 12'o0000, 0, 12'o0000);
        add_row("tad",         12'o1000, 12'o1234, 0, 1, 12'o1234, 0, 12'o0000);
        add_row("mql",         12'o7421, 12'o0000, 0, 1, 12'o0000, 0, 12'o1234);
        add_row("tad",         12'o1000, 12'o0070, 0, 1, 12'o0070, 0, 12'o1234);
        add_row("mqa",         12'o7501, 12'o0000, 0, 1, 12'o1274, 0, 12'o1234);
        add_row("swp",         12'o7521, 12'o0000, 0, 1, 12'o1234, 0, 12'o1274);
        add_row("acl",         12'o7701, 12'o0000, 0, 1, 12'o1274, 0, 12'o1274);
        add_row("cam",         12'o7621, 12'o0000, 0, 1, 12'o0000, 0, 12'o0000);
        add_row("tad",         12'o1000, 12'o0000, 1, 0, 12'o0000, 0, 12'o0000);
        add_row("cia",         12'o7041, 12'o0000, 0, 0, 12'o0000, 0, 12'o0000);
        add_row("rtl",         12'o7006, 12'o0000, 0, 0, 12'o0000, 0, 12'o0000);
        add_row("cll cml ral", 12'o7124, 12'o0000, 0, 0, 12'o0000, 0, 12'o0000);
        add_row("rar",         12'o7010, 12'o0000, 0, 0, 12'o0000, 0, 12'o0000);
        for (int k = 0; k < 2; k++)
        begin
            add_row("cla cll", 12'o7300, 12'o0000, 0, 0, 12'o0000, 0, 12'o0000);
            add_row("tad",     12'o1000, 12'o0000, 1, 0, 12'o0000, 0, 12'o0000);
            add_row("mql",     12'o7421, 12'o0000, 0, 0, 12'o0000, 0, 12'o0000);
            add_row("tad",     12'o1000, 12'o0000, 1, 0, 12'o0000, 0, 12'o0000);
            add_row("mul",     12'o7405, 12'o0000, 1, 0, 12'o0000, 0, 12'o0000);
        end
        add_row("cla cll",     12'o7300, 12'o0000, 0, 0, 12'o0000, 0, 12'o0000);
        add_row("tad",         12'o1000, 12'o7777, 0, 0, 12'o0000, 0, 12'o0000);
        add_row("mql",         12'o7421, 12'o0000, 0, 0, 12'o0000, 0, 12'o0000);
        add_row("mul",         12'o7405, 12'o7777, 0, 1, 12'o7776, 0, 12'o0001);
    endtask

    task automatic run_row(input int idx);
        ac_pkg::word_t op;
        bit            is_mul;
        int            cycles;
        int            exp_cycles;
        int            errs_before;
        errs_before = error_cnt;
        op          = tab_rand[idx] ? ac_pkg::word_t'($urandom) : tab_operand[idx];
        is_mul      = (tab_instr[idx] == 12'o7405);
        exp_cycles  = is_mul ? 3 + `AC_MUL_STEPS : 3;
        @(negedge clk);
        check_link("busy", busy, 1'b0);         // idle before the start
        start   = 1'b1;
        instr   = tab_instr[idx];
        operand = op;
        cycles  = 0;
        while (!done)
        begin
            @(negedge clk);
            cycles++;
            check_link("busy", busy, 1'b1);     // held through the done cycle
            start   = is_mul && (cycles == 6);   // stray start mid multiply
            instr   = start ? 12'o7200 : ac_pkg::instr_t'($urandom);
            operand = ac_pkg::word_t'($urandom);
        end
        model_step(tab_instr[idx], op);
        if (tab_fixed[idx])
        begin
            m_ac = tab_ac[idx];
            m_l  = tab_l[idx];
            m_mq = tab_mq[idx];
        end
        check_word("ac", ac, m_ac);
        check_link("l", l, m_l);
        check_word("mq", mq, m_mq);
        if (cycles - 1 != exp_cycles)
        begin
            $display("%0t: done came %0d cycles after start, expected %0d",
                     $time, cycles - 1, exp_cycles);
            error_cnt++;
        end
        if (error_cnt == errs_before)
            pass_cnt++;
        else
            fail_cnt++;
        $display("row %0d %s instr %o operand %o: ac %o l %b mq %o, %s", idx, tab_name[idx],
                 tab_instr[idx], op, ac, l, mq, (error_cnt == errs_before) ? "ok" : "bad");
    endtask

    initial
    begin
        void'($urandom(38));
        reset   = 1'b1;
        start   = 1'b0;
        instr   = '0;
        operand = '0;
        build_table();
        limit_cycles = tab_instr.size() * 20 + 8 + 50;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_word("ac", ac, '0);
        check_link("l", l, 1'b0);
        check_word("mq", mq, '0);
        if (error_cnt == 0)
            pass_cnt++;
        else
            fail_cnt++;
        $display("reset values: ac %o l %b mq %o", ac, l, mq);
        for (int r = 0; r < tab_instr.size(); r++)
            run_row(r);
        $display("%0d tests, %0d passed, %0d failed, %0d check errors",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, error_cnt);
        if (error_cnt == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: src.f
+incdir+.
ac_pkg.sv
ac_sequencer.sv
opr1_logic.sv
eae_multiplier.sv
ac_datapath.sv
ac_unit_top.sv
ac_unit_props.sv
tb_ac_unit.sv

// File: Bender.yml
package:
  name: ac_unit

sources:
  - include_dirs:
      - .
    files:
      - ac_pkg.sv
      - ac_sequencer.sv
      - opr1_logic.sv
      - eae_multiplier.sv
      - ac_datapath.sv
      - ac_unit_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ac_unit_props.sv
      - tb_ac_unit.sv
